// ==== sources.f ====
src/scene_pkg.sv
src/spi_cmd_rx.sv
src/scene_store.sv
src/inst_table.sv
src/scene_loader_top.sv
tb/tb_scene_loader.sv

// ==== Bender.yml ====
package:
  name: scene_loader

sources:
  - files:
      - src/scene_pkg.sv
      - src/spi_cmd_rx.sv
      - src/scene_store.sv
      - src/inst_table.sv
      - src/scene_loader_top.sv
  - target: test
    files:
      - tb/tb_scene_loader.sv

// ==== tb/tb_scene_loader.sv ====
module tb_scene_loader;

    localparam int VERT_DEPTH = 32;
    localparam int TRI_DEPTH  = 16;
    localparam int INST_DEPTH = 8;

    logic                   sck;
    logic                   rst;
    logic                   cs_n;
    logic [3:0]             mosi;
    logic                   miso;
    logic [7:0]             vert_rd_addr;
    scene_pkg::vertex_t     vert_rd_data;
    logic [7:0]             tri_rd_addr;
    scene_pkg::tri_t        tri_rd_data;
    logic [7:0]             inst_rd_id;
    scene_pkg::inst_entry_t inst_rd;

    // Scene model
    scene_pkg::vertex_t     vert_m [VERT_DEPTH];
    scene_pkg::tri_t        tri_m  [TRI_DEPTH];
    scene_pkg::inst_entry_t inst_m [INST_DEPTH];
    int                     vert_ptr;
    int                     tri_ptr;
    int                     next_id;

    integer seed;
    int     errors;
    int     checks;
    int     test_errs;

    scene_loader_top #(
        .VERT_DEPTH (VERT_DEPTH),
        .TRI_DEPTH  (TRI_DEPTH),
        .INST_DEPTH (INST_DEPTH)
    ) i_dut (
        .sck            (sck),
        .rst            (rst),
        .cs_n_i         (cs_n),
        .mosi_i         (mosi),
        .miso_o         (miso),
        .vert_rd_addr_i (vert_rd_addr),
        .vert_rd_data_o (vert_rd_data),
        .tri_rd_addr_i  (tri_rd_addr),
        .tri_rd_data_o  (tri_rd_data),
        .inst_rd_id_i   (inst_rd_id),
        .inst_rd_o      (inst_rd)
    );

    initial begin
        sck = 1'b0;
        forever #10 sck = ~sck;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_count(input int max);
        return 1 + int'(rand_word() % max);
    endfunction

    function automatic scene_pkg::transform_t random_xform();
        scene_pkg::transform_t xf;
        for (int i = 0; i < 9; i++) begin
            xf.w[i] = rand_word();
        end
        return xf;
    endfunction

    task automatic tick();
        @(posedge sck);
        #2;  // Inputs change just after the edge
    endtask

    task automatic compare(input logic [511:0] got, input logic [511:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic put_nibble(input logic [3:0] nib);
        cs_n = 1'b0;
        mosi = nib;
        tick();
    endtask

    task automatic put_field(input logic [287:0] data, input int nibs);
        for (int i = nibs - 1; i >= 0; i--) begin
            put_nibble(data[i*4 +: 4]);
        end
    endtask

    // Two idle cycles after the last nibble, then one bit per cycle
    task automatic get_response(input int len, output logic [11:0] resp);
        mosi = 4'h0;  // Unknown opcode is harmless once the response ends
        resp = '0;
        tick();
        tick();
        for (int i = 0; i < len; i++) begin
            resp = {resp[10:0], miso};
            if (i < len - 1) tick();
        end
    endtask

    task automatic wait_miso_low(input string what);
        int n;
        n = 0;
        while (miso !== 1'b0 && n < 20) begin
            tick();
            n++;
        end
        if (miso !== 1'b0) begin
            $display("Timeout: miso_o did not return low after %s", what);
            $display("Regression failed");
            $finish;
        end
    endtask

    task automatic reset_model();
        vert_ptr = 0;
        tri_ptr  = 0;
        next_id  = 1;
        for (int i = 0; i < INST_DEPTH; i++) begin
            inst_m[i] = '0;
        end
    endtask

    task automatic create_buf(input bit is_tri, input int n);
        logic [127:0] bits;
        logic [11:0]  resp;
        logic         ovf;
        int           base;
        base = is_tri ? tri_ptr : vert_ptr;
        ovf  = 1'b0;
        put_nibble(is_tri ? scene_pkg::OP_CREATE_TRI : scene_pkg::OP_CREATE_VERT);
        put_field(n - 1, 2);  // Count minus one
        for (int i = 0; i < n; i++) begin
            bits = {rand_word(), rand_word(), rand_word(), rand_word()};
            if (is_tri) begin
                put_field(bits[23:0], 6);
                if (tri_ptr < TRI_DEPTH) begin
                    tri_m[tri_ptr] = bits[23:0];
                    tri_ptr++;
                end else ovf = 1'b1;
            end else begin
                put_field(bits[107:0], 27);
                if (vert_ptr < VERT_DEPTH) begin
                    vert_m[vert_ptr] = bits[107:0];
                    vert_ptr++;
                end else ovf = 1'b1;
            end
        end
        get_response(12, resp);
        compare(resp[11:4], base, is_tri ? "triangle buffer id" : "vertex buffer id");
        compare(resp[3:0], {ovf, 3'b000}, "buffer status");
    endtask

    task automatic create_inst(input logic [7:0] vid, input logic [7:0] tid);
        scene_pkg::transform_t xf;
        logic [11:0]           resp;
        logic [3:0]            st;
        int                    id;
        xf = random_xform();
        id = 0;
        st = 4'hA;  // Table full reports overflow and table_full
        if (next_id < INST_DEPTH) begin
            id         = next_id;
            inst_m[id] = '{valid: 1'b1, vert_id: vid, tri_id: tid, xform: xf};
            next_id++;
            st = 4'h0;
        end
        put_nibble(scene_pkg::OP_CREATE_INST);
        put_field(vid, 2);
        put_field(tid, 2);
        put_field(xf, 72);
        get_response(12, resp);
        compare(resp[11:4], id, "instance id");
        compare(resp[3:0], st, "instance create status");
    endtask

    task automatic update_inst(input logic [7:0] id);
        scene_pkg::transform_t xf;
        logic [11:0]           resp;
        logic                  ok;
        xf = random_xform();
        ok = 1'b0;
        if (id < INST_DEPTH) ok = inst_m[id].valid;
        if (ok) inst_m[id].xform = xf;
        put_nibble(scene_pkg::OP_UPDATE_INST);
        put_field(id, 2);
        put_field(xf, 72);
        get_response(4, resp);
        compare(resp[3:0], ok ? 4'h0 : 4'h4, "instance update status");
    endtask

    task automatic wipe_scene();
        logic [11:0] resp;
        put_nibble(scene_pkg::OP_WIPE);
        get_response(4, resp);
        compare(resp[3:0], 4'h0, "wipe status");
        reset_model();
    endtask

    task automatic check_stores();
        for (int i = 0; i < vert_ptr; i++) begin
            vert_rd_addr = 8'(i);
            tick();
            compare(vert_rd_data, vert_m[i], $sformatf("vertex %0d", i));
        end
        for (int i = 0; i < tri_ptr; i++) begin
            tri_rd_addr = 8'(i);
            tick();
            compare(tri_rd_data, tri_m[i], $sformatf("triangle %0d", i));
        end
    endtask

    task automatic check_instances();
        for (int i = 0; i < INST_DEPTH; i++) begin
            inst_rd_id = 8'(i);
            tick();
            compare(inst_rd.valid, inst_m[i].valid, $sformatf("instance %0d valid", i));
            if (inst_m[i].valid) compare(inst_rd, inst_m[i], $sformatf("instance %0d", i));
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s done with %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        logic [127:0] bits;
        seed         = 32'h928c_901e;
        errors       = 0;
        checks       = 0;
        test_errs    = 0;
        rst          = 1'b1;
        cs_n         = 1'b1;
        mosi         = 4'h0;
        vert_rd_addr = '0;
        tri_rd_addr  = '0;
        inst_rd_id   = '0;
        reset_model();
        repeat (3) @(posedge sck);
        #2;
        rst = 1'b0;
        wait_miso_low("reset");

        repeat (3) create_buf(1'b0, rand_count(4));
        check_stores();
        end_test("vertex buffers");

        repeat (3) begin
            create_buf(1'b1, rand_count(3));
            create_buf(1'b0, rand_count(3));
        end
        check_stores();
        end_test("triangle buffers");

        repeat (3) create_inst(8'(rand_word()), 8'(rand_word()));
        update_inst(8'(rand_count(3)));
        update_inst(8'd2);
        update_inst(8'd6);  // Not allocated yet
        update_inst(8'd0);  // Camera
        check_instances();
        end_test("instances");

        create_buf(1'b0, VERT_DEPTH - vert_ptr + 3);
        create_buf(1'b1, TRI_DEPTH - tri_ptr + 2);
        while (next_id < INST_DEPTH) create_inst(8'(rand_word()), 8'(rand_word()));
        create_inst(8'h01, 8'h02);
        check_stores();
        check_instances();
        end_test("overflow");

        wipe_scene();
        check_instances();
        create_buf(1'b0, 2);
        create_buf(1'b1, 1);
        create_inst(8'h00, 8'h00);
        update_inst(8'd5);  // Leaves bad_id set so a stray status response shows on miso
        put_nibble(4'hB);
        repeat (4) begin
            compare(miso, 1'b0, "miso after unknown opcode");
            put_nibble(4'h0);
        end
        create_buf(1'b1, 2);
        // Two vertices announced and the second cut short by chip select
        put_nibble(scene_pkg::OP_CREATE_VERT);
        put_field(1, 2);
        bits = {rand_word(), rand_word(), rand_word(), rand_word()};
        put_field(bits[107:0], 27);
        vert_m[vert_ptr] = bits[107:0];
        vert_ptr++;
        put_field(rand_word(), 8);
        cs_n = 1'b1;
        mosi = 4'h0;
        tick();
        tick();
        wait_miso_low("chip select release");
        create_buf(1'b0, 2);
        check_stores();
        check_instances();
        end_test("robustness");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== src/scene_loader_top.sv ====
module scene_loader_top #(
    parameter int VERT_DEPTH = scene_pkg::DEF_DEPTH,
    parameter int TRI_DEPTH  = scene_pkg::DEF_DEPTH,
    parameter int INST_DEPTH = scene_pkg::DEF_DEPTH
) (
    input  logic                   sck,
    input  logic                   rst,
    input  logic                   cs_n_i,
    input  logic [3:0]             mosi_i,
    output logic                   miso_o,

    input  logic [7:0]             vert_rd_addr_i,
    output scene_pkg::vertex_t     vert_rd_data_o,
    input  logic [7:0]             tri_rd_addr_i,
    output scene_pkg::tri_t        tri_rd_data_o,
    input  logic [7:0]             inst_rd_id_i,
    output scene_pkg::inst_entry_t inst_rd_o
);

    logic                 vert_start;
    logic                 vert_wr;
    scene_pkg::vertex_t   vert_item;
    logic [7:0]           vert_base;
    logic                 vert_ovf;
    logic                 tri_start;
    logic                 tri_wr;
    scene_pkg::tri_t      tri_item;
    logic [7:0]           tri_base;
    logic                 tri_ovf;
    scene_pkg::inst_cmd_t inst_cmd;
    logic [7:0]           inst_id;
    scene_pkg::status_t   inst_status;
    logic                 wipe;

    spi_cmd_rx i_rx (
        .sck, .rst, .cs_n_i, .mosi_i, .miso_o,
        .vert_start_o  (vert_start),
        .vert_wr_o     (vert_wr),
        .vert_item_o   (vert_item),
        .vert_base_i   (vert_base),
        .vert_ovf_i    (vert_ovf),
        .tri_start_o   (tri_start),
        .tri_wr_o      (tri_wr),
        .tri_item_o    (tri_item),
        .tri_base_i    (tri_base),
        .tri_ovf_i     (tri_ovf),
        .inst_cmd_o    (inst_cmd),
        .inst_id_i     (inst_id),
        .inst_status_i (inst_status),
        .wipe_o        (wipe)
    );

    scene_store #(.item_t(scene_pkg::vertex_t), .DEPTH(VERT_DEPTH)) i_vert_store (
        .sck, .rst,
        .start_i (vert_start), .wr_i (vert_wr), .item_i (vert_item), .wipe_i (wipe),
        .base_o  (vert_base), .overflow_o (vert_ovf),
        .rd_addr_i (vert_rd_addr_i), .rd_data_o (vert_rd_data_o)
    );

    scene_store #(.item_t(scene_pkg::tri_t), .DEPTH(TRI_DEPTH)) i_tri_store (
        .sck, .rst,
        .start_i (tri_start), .wr_i (tri_wr), .item_i (tri_item), .wipe_i (wipe),
        .base_o  (tri_base), .overflow_o (tri_ovf),
        .rd_addr_i (tri_rd_addr_i), .rd_data_o (tri_rd_data_o)
    );

    inst_table #(.DEPTH(INST_DEPTH)) i_inst_table (
        .sck, .rst,
        .cmd_i      (inst_cmd),
        .wipe_i     (wipe),
        .alloc_id_o (inst_id),
        .status_o   (inst_status),
        .rd_id_i    (inst_rd_id_i),
        .rd_o       (inst_rd_o)
    );

endmodule

// ==== src/inst_table.sv ====
module inst_table #(
    parameter int DEPTH = scene_pkg::DEF_DEPTH
) (
    input  logic                   sck,
    input  logic                   rst,
    input  scene_pkg::inst_cmd_t   cmd_i,
    input  logic                   wipe_i,
    output logic [7:0]             alloc_id_o,
    output scene_pkg::status_t     status_o,
    input  logic [7:0]             rd_id_i,
    output scene_pkg::inst_entry_t rd_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    scene_pkg::inst_entry_t mem [DEPTH];
    logic [DEPTH-1:0]       valid_q;
    logic [8:0]             next_id_q;  // Id 0 belongs to the camera
    logic                   can_alloc;
    logic                   upd_ok;

    assign can_alloc = (next_id_q < DEPTH);
    assign upd_ok    = (cmd_i.id < DEPTH) && valid_q[cmd_i.id[AW-1:0]];

    always_ff @(posedge sck) begin
        if (rst || wipe_i) begin
            valid_q    <= '0;
            next_id_q  <= 9'd1;
            alloc_id_o <= '0;
            status_o   <= '0;
        end else if (cmd_i.create) begin
            status_o <= '0;
            if (can_alloc) begin
                valid_q[next_id_q[AW-1:0]] <= 1'b1;
                alloc_id_o <= next_id_q[7:0];
                next_id_q  <= next_id_q + 9'd1;
            end else begin
                alloc_id_o          <= '0;
                status_o.table_full <= 1'b1;
                status_o.overflow   <= 1'b1;
            end
        end else if (cmd_i.update) begin
            status_o        <= '0;
            status_o.bad_id <= !upd_ok;
        end
    end

    always_ff @(posedge sck) begin
        if (!wipe_i) begin
            if (cmd_i.create && can_alloc) begin
                mem[next_id_q[AW-1:0]] <= '{valid:   1'b1,
                                            vert_id: cmd_i.vert_id,
                                            tri_id:  cmd_i.tri_id,
                                            xform:   cmd_i.xform};
            end else if (cmd_i.update && upd_ok) begin
                mem[cmd_i.id[AW-1:0]].xform <= cmd_i.xform;  // Buffer ids kept
            end
        end
    end

    // Valid comes from the flag vector, stale entries read as empty
    always_ff @(posedge sck) begin
        rd_o       <= mem[rd_id_i[AW-1:0]];
        rd_o.valid <= (rd_id_i < DEPTH) && valid_q[rd_id_i[AW-1:0]];
    end

endmodule

// ==== src/scene_store.sv ====
module scene_store #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = scene_pkg::DEF_DEPTH
) (
    input  logic       sck,
    input  logic       rst,
    input  logic       start_i,
    input  logic       wr_i,
    input  item_t      item_i,
    input  logic       wipe_i,
    output logic [7:0] base_o,
    output logic       overflow_o,
    input  logic [7:0] rd_addr_i,
    output item_t      rd_data_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t       mem [DEPTH];
    logic [AW:0] ptr_q;  // One bit wider so a full store can be told apart
    logic        room;

    assign room = (ptr_q < DEPTH);

    always_ff @(posedge sck) begin
        if (rst) begin
            ptr_q      <= '0;
            base_o     <= '0;
            overflow_o <= 1'b0;
        end else if (wipe_i) begin
            ptr_q      <= '0;
            base_o     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (start_i) begin
                base_o     <= 8'(ptr_q);  // Buffer id is its first index
                overflow_o <= 1'b0;
            end
            if (wr_i) begin
                if (room) ptr_q <= ptr_q + 1'b1;
                else overflow_o <= 1'b1;  // Item dropped
            end
        end
    end

    always_ff @(posedge sck) begin
        if (wr_i && room && !wipe_i) begin
            mem[ptr_q[AW-1:0]] <= item_i;
        end
    end

    // Raster read, one cycle latency
    always_ff @(posedge sck) begin
        rd_data_o <= mem[rd_addr_i[AW-1:0]];
    end

endmodule

// ==== src/spi_cmd_rx.sv ====
module spi_cmd_rx (
    input  logic                  sck,
    input  logic                  rst,
    input  logic                  cs_n_i,
    input  logic [3:0]            mosi_i,
    output logic                  miso_o,

    output logic                  vert_start_o,
    output logic                  vert_wr_o,
    output scene_pkg::vertex_t    vert_item_o,
    input  logic [7:0]            vert_base_i,
    input  logic                  vert_ovf_i,

    output logic                  tri_start_o,
    output logic                  tri_wr_o,
    output scene_pkg::tri_t       tri_item_o,
    input  logic [7:0]            tri_base_i,
    input  logic                  tri_ovf_i,

    output scene_pkg::inst_cmd_t  inst_cmd_o,
    input  logic [7:0]            inst_id_i,
    input  scene_pkg::status_t    inst_status_i,
    output logic                  wipe_o
);

    localparam int XFORM_W   = $bits(scene_pkg::transform_t);
    localparam int NIB_VERT  = $bits(scene_pkg::vertex_t) / 4;
    localparam int NIB_TRI   = $bits(scene_pkg::tri_t) / 4;
    localparam int NIB_XFORM = XFORM_W / 4;

    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_COUNT,
        ST_ITEMS,   // Vertex or triangle bodies
        ST_HDR,     // Instance header or update id
        ST_XFORM,
        ST_WR,
        ST_SETTLE,
        ST_RESP
    } state_e;

    state_e               state_q;
    scene_pkg::opcode_e   op_q;
    logic [6:0]           nib_cnt_q;
    logic [6:0]           nib_len;
    logic                 nib_last;
    logic [7:0]           item_cnt_q;
    logic [3:0]           bit_cnt_q;
    logic [11:0]          resp_q;
    logic [11:0]          resp_d;
    logic [3:0]           resp_len;
    scene_pkg::status_t   st;
    logic [XFORM_W-1:0]   shift_q;
    logic [XFORM_W-1:0]   shift_d;
    logic [7:0]           id_q;
    logic [7:0]           vid_q;
    logic [7:0]           tid_q;
    logic                 create_q;
    logic                 update_q;

    assign shift_d = {shift_q[XFORM_W-5:0], mosi_i};

    always_comb begin
        case (state_q)
            ST_COUNT: nib_len = 7'd2;
            ST_ITEMS: nib_len = (op_q == scene_pkg::OP_CREATE_TRI) ? 7'(NIB_TRI) : 7'(NIB_VERT);
            ST_HDR:   nib_len = (op_q == scene_pkg::OP_CREATE_INST) ? 7'd4 : 7'd2;
            ST_XFORM: nib_len = 7'(NIB_XFORM);
            default:  nib_len = 7'd1;
        endcase
    end

    assign nib_last = (nib_cnt_q == nib_len - 7'd1);

    // Response word, MSB first on miso_o
    always_comb begin
        st       = '0;
        resp_d   = '0;
        resp_len = 4'd4;
        case (op_q)
            scene_pkg::OP_CREATE_VERT: begin
                st.overflow = vert_ovf_i;
                resp_d      = {vert_base_i, st};
                resp_len    = 4'd12;
            end
            scene_pkg::OP_CREATE_TRI: begin
                st.overflow = tri_ovf_i;
                resp_d      = {tri_base_i, st};
                resp_len    = 4'd12;
            end
            scene_pkg::OP_CREATE_INST: begin
                resp_d   = {inst_id_i, inst_status_i};
                resp_len = 4'd12;
            end
            scene_pkg::OP_UPDATE_INST: resp_d = {inst_status_i, 8'h00};
            default: begin
                // Wipe reports whatever is still set afterwards
                st          = inst_status_i;
                st.overflow = st.overflow | vert_ovf_i | tri_ovf_i;
                resp_d      = {st, 8'h00};
            end
        endcase
    end

    always_ff @(posedge sck) begin
        if (rst) begin
            state_q      <= ST_OPCODE;
            op_q         <= scene_pkg::opcode_e'(4'h0);
            nib_cnt_q    <= '0;
            item_cnt_q   <= '0;
            bit_cnt_q    <= '0;
            resp_q       <= '0;
            vert_start_o <= 1'b0;
            vert_wr_o    <= 1'b0;
            tri_start_o  <= 1'b0;
            tri_wr_o     <= 1'b0;
            create_q     <= 1'b0;
            update_q     <= 1'b0;
            wipe_o       <= 1'b0;
        end else begin
            vert_start_o <= 1'b0;
            vert_wr_o    <= 1'b0;
            tri_start_o  <= 1'b0;
            tri_wr_o     <= 1'b0;
            create_q     <= 1'b0;
            update_q     <= 1'b0;
            wipe_o       <= 1'b0;
            resp_q       <= resp_q << 1;
            if (cs_n_i) begin
                state_q   <= ST_OPCODE;  // Drops any partial item
                nib_cnt_q <= '0;
                resp_q    <= '0;
            end else begin
                case (state_q)
                    ST_OPCODE: begin
                        op_q      <= scene_pkg::opcode_e'(mosi_i);
                        nib_cnt_q <= '0;
                        case (scene_pkg::opcode_e'(mosi_i))
                            scene_pkg::OP_CREATE_VERT: begin
                                vert_start_o <= 1'b1;
                                state_q      <= ST_COUNT;
                            end
                            scene_pkg::OP_CREATE_TRI: begin
                                tri_start_o <= 1'b1;
                                state_q     <= ST_COUNT;
                            end
                            scene_pkg::OP_CREATE_INST: state_q <= ST_HDR;
                            scene_pkg::OP_UPDATE_INST: state_q <= ST_HDR;
                            scene_pkg::OP_WIPE: begin
                                wipe_o  <= 1'b1;
                                state_q <= ST_WR;
                            end
                            default: state_q <= ST_OPCODE;  // Unknown, next nibble is an opcode
                        endcase
                    end
                    ST_COUNT: begin
                        nib_cnt_q <= nib_last ? 7'd0 : nib_cnt_q + 7'd1;
                        if (nib_last) begin
                            item_cnt_q <= shift_d[7:0];  // Count minus one
                            state_q    <= ST_ITEMS;
                        end
                    end
                    ST_ITEMS: begin
                        nib_cnt_q <= nib_last ? 7'd0 : nib_cnt_q + 7'd1;
                        if (nib_last) begin
                            if (op_q == scene_pkg::OP_CREATE_TRI) tri_wr_o <= 1'b1;
                            else vert_wr_o <= 1'b1;
                            if (item_cnt_q == 8'd0) state_q <= ST_WR;
                            else item_cnt_q <= item_cnt_q - 8'd1;
                        end
                    end
                    ST_HDR: begin
                        nib_cnt_q <= nib_last ? 7'd0 : nib_cnt_q + 7'd1;
                        if (nib_last) state_q <= ST_XFORM;
                    end
                    ST_XFORM: begin
                        nib_cnt_q <= nib_last ? 7'd0 : nib_cnt_q + 7'd1;
                        if (nib_last) begin
                            if (op_q == scene_pkg::OP_CREATE_INST) create_q <= 1'b1;
                            else update_q <= 1'b1;
                            state_q <= ST_WR;
                        end
                    end
                    ST_WR: state_q <= ST_SETTLE;  // Write lands on this edge
                    ST_SETTLE: begin
                        resp_q    <= resp_d;
                        bit_cnt_q <= resp_len - 4'd1;
                        state_q   <= ST_RESP;
                    end
                    default: begin
                        // Leave on the last bit so the next edge samples an opcode
                        bit_cnt_q <= bit_cnt_q - 4'd1;
                        if (bit_cnt_q == 4'd1) state_q <= ST_OPCODE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sck) begin
        if (!cs_n_i) begin
            shift_q <= shift_d;
            if (state_q == ST_HDR && nib_last) begin
                if (op_q == scene_pkg::OP_CREATE_INST) begin
                    vid_q <= shift_d[15:8];
                    tid_q <= shift_d[7:0];
                end else begin
                    id_q <= shift_d[7:0];
                end
            end
        end
    end

    assign vert_item_o = scene_pkg::vertex_t'(shift_q[$bits(scene_pkg::vertex_t)-1:0]);
    assign tri_item_o  = scene_pkg::tri_t'(shift_q[$bits(scene_pkg::tri_t)-1:0]);

    always_comb begin
        inst_cmd_o.create  = create_q;
        inst_cmd_o.update  = update_q;
        inst_cmd_o.id      = id_q;
        inst_cmd_o.vert_id = vid_q;
        inst_cmd_o.tri_id  = tid_q;
        inst_cmd_o.xform   = scene_pkg::transform_t'(shift_q);
    end

    assign miso_o = resp_q[11];

endmodule

// ==== src/scene_pkg.sv ====
package scene_pkg;

    parameter int DEF_DEPTH = 256;  // Upper bound too, ids are ID_W bits
    parameter int ID_W      = 8;

    typedef enum logic [3:0] {
        OP_CREATE_VERT = 4'h1,
        OP_CREATE_TRI  = 4'h2,
        OP_CREATE_INST = 4'h3,
        OP_UPDATE_INST = 4'h4,
        OP_WIPE        = 4'h5
    } opcode_e;

    // 27 nibbles on the wire, x first
    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [3:0]  attr0;
        logic [3:0]  attr1;
        logic [3:0]  attr2;
    } vertex_t;

    typedef struct packed {
        logic [ID_W-1:0] v0;
        logic [ID_W-1:0] v1;
        logic [ID_W-1:0] v2;
    } tri_t;

    // Nine words, w[8] is sent first
    typedef struct packed {
        logic [8:0][31:0] w;
    } transform_t;

    typedef struct packed {
        logic overflow;    // At least one write dropped
        logic bad_id;      // Update of an unallocated instance
        logic table_full;  // No free instance id
        logic spare;
    } status_t;

    typedef struct packed {
        logic            create;
        logic            update;
        logic [ID_W-1:0] id;
        logic [ID_W-1:0] vert_id;
        logic [ID_W-1:0] tri_id;
        transform_t      xform;
    } inst_cmd_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] vert_id;
        logic [ID_W-1:0] tri_id;
        transform_t      xform;
    } inst_entry_t;

endpackage
